// ==== cam_msg_top.f ====
+incdir+include
hw/cam_pkg.sv
hw/cam_range_encoder.sv
hw/cam.sv
hw/cam_cntrl.sv
hw/msg_desc_fifo.sv
hw/cam_msg_top.sv
dv/cam_msg_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing
TOP         = cam_msg_tb
FILELIST    = cam_msg_top.f
PASS_MSG    = Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== dv/cam_msg_tb.sv ====
`timescale 1ns/1ps

`include "cam_macros.svh"

module cam_msg_tb;

	import cam_pkg::*;

	localparam int NUM_ENTRIES = 1 << `CAM_ADDR_WIDTH;
	localparam int FIFO_DEPTH  = `MSG_FIFO_DEPTH;
	localparam int TIMEOUT     = 100;

	logic clk;
	logic rst;
	logic wr_cs_i;
	logic wr_en_i;
	cam_data_t data_i;
	logic start_message_i;
	logic end_message_i;
	cam_data_t find_tag_i;
	logic search_tag_i;
	cam_addr_t start_index_i;
	cam_addr_t end_index_i;
	logic pop_i;

	cam_addr_t start_addr_o;
	cam_addr_t end_addr_o;
	logic store_start_o;
	logic store_end_o;
	logic tag_match_o;
	cam_addr_t index_value_o;
	logic search_done_o;
	logic full_o;
	msg_desc_t desc_o;
	logic desc_empty_o;
	logic desc_overflow_o;

	// reference model state.
	cam_data_t m_data [NUM_ENTRIES];
	logic      m_valid [NUM_ENTRIES];
	cam_addr_t m_ptr;
	int        m_writes;
	logic      m_full;
	cam_addr_t m_start_addr;
	cam_addr_t m_end_addr;
	logic      m_store_start;
	logic      m_store_end;
	logic      m_match;
	cam_addr_t m_index;
	logic      m_done;
	msg_desc_t m_q[$];
	logic      m_overflow;

	logic [31:0] lcg_state;
	int errors;
	int checks;

	cam_msg_top u_dut (
		.clk             (clk),
		.rst             (rst),
		.wr_cs_i         (wr_cs_i),
		.wr_en_i         (wr_en_i),
		.data_i          (data_i),
		.start_message_i (start_message_i),
		.end_message_i   (end_message_i),
		.find_tag_i      (find_tag_i),
		.search_tag_i    (search_tag_i),
		.start_index_i   (start_index_i),
		.end_index_i     (end_index_i),
		.pop_i           (pop_i),
		.start_addr_o    (start_addr_o),
		.end_addr_o      (end_addr_o),
		.store_start_o   (store_start_o),
		.store_end_o     (store_end_o),
		.tag_match_o     (tag_match_o),
		.index_value_o   (index_value_o),
		.search_done_o   (search_done_o),
		.full_o          (full_o),
		.desc_o          (desc_o),
		.desc_empty_o    (desc_empty_o),
		.desc_overflow_o (desc_overflow_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// a small pool of words, so stored values repeat and searches hit.
	function automatic cam_data_t pool_word(input logic [3:0] k);
		return {28'h5a5a5a5, k};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t",
				name, got, exp, $time);
		end
	endtask

	task automatic model_reset();
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			m_data[i]  = '0;
			m_valid[i] = 1'b0;
		end
		m_ptr         = '0;
		m_writes      = 0;
		m_full        = 1'b0;
		m_start_addr  = '0;
		m_end_addr    = '0;
		m_store_start = 1'b0;
		m_store_end   = 1'b0;
		m_match       = 1'b0;
		m_index       = '0;
		m_done        = 1'b0;
		m_overflow    = 1'b0;
		m_q.delete();
	endtask

	// one rising edge of the model. every step reads the state from before the edge.
	task automatic model_step();
		msg_desc_t d;
		logic      do_pop;
		logic      do_push;
		logic      found;
		cam_addr_t idx;
		if (search_tag_i) begin
			found = 1'b0;
			idx   = '0;
			for (int i = 0; i < NUM_ENTRIES; i++) begin
				if (!found && i >= int'(start_index_i) && i <= int'(end_index_i) &&
						m_valid[i] && m_data[i] == find_tag_i) begin
					found = 1'b1;
					idx   = cam_addr_t'(i);
				end
			end
			m_match = found;
			m_index = idx;
		end
		m_done = search_tag_i;
		// a pop in the same cycle frees a slot for the push.
		do_pop       = pop_i && (m_q.size() != 0);
		do_push      = m_store_end && (m_q.size() < FIFO_DEPTH || do_pop);
		d.start_addr = m_start_addr;
		d.end_addr   = m_end_addr;
		if (m_store_end && !do_push) begin
			m_overflow = 1'b1;
		end
		if (do_pop) begin
			m_q.delete(0);
		end
		if (do_push) begin
			m_q.push_back(d);
		end
		m_store_start = start_message_i;
		m_store_end   = end_message_i && !start_message_i;
		if (start_message_i) begin
			m_start_addr = m_ptr;
		end else if (end_message_i) begin
			m_end_addr = m_ptr;
		end
		if (wr_cs_i && wr_en_i && m_writes < NUM_ENTRIES) begin
			m_data[m_ptr]  = data_i;
			m_valid[m_ptr] = 1'b1;
			m_ptr          = m_ptr + 1'b1;
			m_writes++;
		end
		m_full = (m_writes == NUM_ENTRIES);
	endtask

	task automatic check_outputs();
		msg_desc_t exp_desc;
		exp_desc = (m_q.size() > 0) ? m_q[0] : '0;
		check_value("start_addr_o", 32'(start_addr_o), 32'(m_start_addr));
		check_value("end_addr_o", 32'(end_addr_o), 32'(m_end_addr));
		check_value("store_start_o", 32'(store_start_o), 32'(m_store_start));
		check_value("store_end_o", 32'(store_end_o), 32'(m_store_end));
		check_value("tag_match_o", 32'(tag_match_o), 32'(m_match));
		check_value("index_value_o", 32'(index_value_o), 32'(m_index));
		check_value("search_done_o", 32'(search_done_o), 32'(m_done));
		check_value("full_o", 32'(full_o), 32'(m_full));
		check_value("desc_o", 32'(desc_o), 32'(exp_desc));
		check_value("desc_empty_o", 32'(desc_empty_o), 32'(m_q.size() == 0));
		check_value("desc_overflow_o", 32'(desc_overflow_o), 32'(m_overflow));
	endtask

	task automatic set_idle();
		wr_cs_i         = 1'b0;
		wr_en_i         = 1'b0;
		start_message_i = 1'b0;
		end_message_i   = 1'b0;
		pop_i           = 1'b0;
		search_tag_i    = 1'b0;
	endtask

	// outputs are compared at the falling edge and inputs change 1 ns after the rising edge.
	task automatic tick();
		@(negedge clk);
		check_outputs();
		@(posedge clk);
		model_step();
		#1;
		set_idle();
	endtask

	task automatic drive_random();
		logic [31:0] r;
		logic [31:0] s;
		r = next_rand();
		s = next_rand();
		wr_cs_i         = r[31];
		wr_en_i         = r[30] | r[29];
		data_i          = pool_word({1'b0, r[28:26]});
		start_message_i = (r[25:22] == 4'd0);
		end_message_i   = (r[21:19] == 3'd0);
		pop_i           = r[18] & r[17];
		search_tag_i    = r[16];
		find_tag_i      = pool_word(s[31:28]);
		start_index_i   = s[27:23];
		end_index_i     = s[20:16];
		if (s[22:21] == 2'd0) begin
			start_index_i = '0;
			end_index_i   = cam_addr_t'(NUM_ENTRIES - 1);
		end
	endtask

	task automatic wait_search_done();
		int n;
		n = 0;
		while (search_done_o !== 1'b1 && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (search_done_o !== 1'b1) begin
			errors++;
			$display("Timed out waiting for search_done_o to rise.");
		end
	endtask

	task automatic wait_full();
		int n;
		n = 0;
		while (full_o !== 1'b1 && n < TIMEOUT) begin
			wr_cs_i = 1'b1;
			wr_en_i = 1'b1;
			data_i  = pool_word(4'(next_rand() >> 28));
			tick();
			n++;
		end
		if (full_o !== 1'b1) begin
			errors++;
			$display("Timed out waiting for full_o to rise.");
		end
	endtask

	task automatic drain_queue();
		int n;
		n = 0;
		while (desc_empty_o !== 1'b1 && n < TIMEOUT) begin
			pop_i = 1'b1;
			tick();
			n++;
		end
		if (desc_empty_o !== 1'b1) begin
			errors++;
			$display("Timed out waiting for the descriptor queue to empty.");
		end
	endtask

	initial begin
		errors          = 0;
		checks          = 0;
		lcg_state       = 32'hfe6b941d;
		rst             = 1'b1;
		data_i          = '0;
		find_tag_i      = '0;
		start_index_i   = '0;
		end_index_i     = '0;
		set_idle();
		model_reset();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		check_outputs();

		// the search must not see the word written at the same edge.
		wr_cs_i       = 1'b1;
		wr_en_i       = 1'b1;
		data_i        = pool_word(4'd3);
		search_tag_i  = 1'b1;
		find_tag_i    = pool_word(4'd3);
		tick();
		wait_search_done();
		check_value("tag_match_o", 32'(tag_match_o), 32'd0);
		wr_cs_i      = 1'b1;
		wr_en_i      = 1'b1;
		search_tag_i = 1'b1;
		tick();
		wait_search_done();
		check_value("tag_match_o", 32'(tag_match_o), 32'd1);
		check_value("index_value_o", 32'(index_value_o), 32'd0);

		// the duplicate at index 1 is found once index 0 lies outside the window.
		search_tag_i  = 1'b1;
		start_index_i = cam_addr_t'(1);
		end_index_i   = cam_addr_t'(NUM_ENTRIES - 1);
		tick();
		wait_search_done();
		check_value("index_value_o", 32'(index_value_o), 32'd1);

		start_message_i = 1'b1;
		end_message_i   = 1'b1;
		tick();
		check_value("store_start_o", 32'(store_start_o), 32'd1);
		check_value("store_end_o", 32'(store_end_o), 32'd0);

		// with no pops, the fifth and sixth descriptors have no room.
		// a write with each end strobe gives every descriptor its own end address.
		for (int k = 0; k < FIFO_DEPTH + 2; k++) begin
			if (k == FIFO_DEPTH) begin
				check_value("desc_overflow_o", 32'(desc_overflow_o), 32'd0);
			end
			wr_cs_i       = 1'b1;
			wr_en_i       = 1'b1;
			end_message_i = 1'b1;
			tick();
			tick();
		end
		check_value("desc_overflow_o", 32'(desc_overflow_o), 32'd1);
		drain_queue();
		tick();

		repeat (200) begin
			drive_random();
			tick();
		end
		wait_full();
		repeat (200) begin
			drive_random();
			tick();
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== hw/cam_msg_top.sv ====
`timescale 1ns/1ps

`include "cam_macros.svh"

module cam_msg_top (
	input  logic                clk,
	input  logic                rst,

	input  logic                wr_cs_i,
	input  logic                wr_en_i,
	input  cam_pkg::cam_data_t  data_i,
	input  logic                start_message_i,
	input  logic                end_message_i,
	input  cam_pkg::cam_data_t  find_tag_i,
	input  logic                search_tag_i,
	input  cam_pkg::cam_addr_t  start_index_i,
	input  cam_pkg::cam_addr_t  end_index_i,
	input  logic                pop_i,

	output cam_pkg::cam_addr_t  start_addr_o,
	output cam_pkg::cam_addr_t  end_addr_o,
	output logic                store_start_o,
	output logic                store_end_o,
	output logic                tag_match_o,
	output cam_pkg::cam_addr_t  index_value_o,
	output logic                search_done_o,
	output logic                full_o,
	output cam_pkg::msg_desc_t  desc_o,
	output logic                desc_empty_o,
	output logic                desc_overflow_o
);

	import cam_pkg::*;

	msg_desc_t push_desc;

	cam_cntrl u_cntrl (
		.clk             (clk),
		.rst             (rst),
		.wr_cs_i         (wr_cs_i),
		.wr_en_i         (wr_en_i),
		.data_i          (data_i),
		.start_message_i (start_message_i),
		.end_message_i   (end_message_i),
		.find_tag_i      (find_tag_i),
		.search_tag_i    (search_tag_i),
		.start_index_i   (start_index_i),
		.end_index_i     (end_index_i),
		.start_addr_o    (start_addr_o),
		.end_addr_o      (end_addr_o),
		.store_start_o   (store_start_o),
		.store_end_o     (store_end_o),
		.tag_match_o     (tag_match_o),
		.index_value_o   (index_value_o),
		.search_done_o   (search_done_o),
		.full_o          (full_o)
	);

	// while store_end is high both addresses already hold the finished message.
	assign push_desc.start_addr = start_addr_o;
	assign push_desc.end_addr   = end_addr_o;

	msg_desc_fifo #(
		.entry_t (msg_desc_t),
		.DEPTH   (`MSG_FIFO_DEPTH)
	) u_desc_fifo (
		.clk         (clk),
		.rst         (rst),
		.push_i      (store_end_o),
		.push_data_i (push_desc),
		.pop_i       (pop_i),
		.data_o      (desc_o),
		.empty_o     (desc_empty_o),
		.overflow_o  (desc_overflow_o)
	);

endmodule

// ==== hw/msg_desc_fifo.sv ====
`timescale 1ns/1ps

module msg_desc_fifo #(
	parameter type entry_t = logic,
	parameter int  DEPTH   = 4
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   push_i,
	input  entry_t push_data_i,
	input  logic   pop_i,
	output entry_t data_o,
	output logic   empty_o,
	output logic   overflow_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	entry_t           slots [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             do_pop;
	logic             do_push;

	assign full    = (count == (PTR_W+1)'(DEPTH));
	assign empty_o = (count == '0);

	// a pop makes room, so a push into a full queue that is popped
	// in the same cycle still goes in.
	assign do_pop  = pop_i && !empty_o;
	assign do_push = push_i && (!full || do_pop);

	// the head slot is shown only while there is something in it.
	assign data_o = empty_o ? entry_t'('0) : slots[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			slots[wr_ptr] <= push_data_i;
		end
	end

	// DEPTH is a power of two, so the pointers wrap on their own.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// a lost descriptor is remembered until reset.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			overflow_o <= 1'b0;
		end else if (push_i && !do_push) begin
			overflow_o <= 1'b1;
		end
	end

endmodule

// ==== hw/cam_cntrl.sv ====
`timescale 1ns/1ps

module cam_cntrl (
	input  logic               clk,
	input  logic               rst,

	input  logic               wr_cs_i,
	input  logic               wr_en_i,
	input  cam_pkg::cam_data_t data_i,
	input  logic               start_message_i,
	input  logic               end_message_i,

	input  cam_pkg::cam_data_t find_tag_i,
	input  logic               search_tag_i,
	input  cam_pkg::cam_addr_t start_index_i,
	input  cam_pkg::cam_addr_t end_index_i,

	output cam_pkg::cam_addr_t start_addr_o,
	output cam_pkg::cam_addr_t end_addr_o,
	output logic               store_start_o,
	output logic               store_end_o,
	output logic               tag_match_o,
	output cam_pkg::cam_addr_t index_value_o,
	output logic               search_done_o,
	output logic               full_o
);

	import cam_pkg::*;

	cam_addr_t wr_ptr;
	logic      wr_accept;
	logic      end_take;

	// writes are blocked for good once every entry has been filled.
	assign wr_accept = wr_cs_i && wr_en_i && !full_o;

	// a start strobe hides an end strobe in the same cycle.
	assign end_take = end_message_i && !start_message_i;

	// after the last entry the pointer wraps to zero, but no write follows.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (wr_accept) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			full_o <= 1'b0;
		end else if (wr_accept && (wr_ptr == '1)) begin
			full_o <= 1'b1;
		end
	end

	// boundaries take the pointer as it was before a write at the same edge.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			start_addr_o <= '0;
			end_addr_o   <= '0;
		end else if (start_message_i) begin
			start_addr_o <= wr_ptr;
		end else if (end_take) begin
			end_addr_o <= wr_ptr;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			store_start_o <= 1'b0;
			store_end_o   <= 1'b0;
		end else begin
			store_start_o <= start_message_i;
			store_end_o   <= end_take;
		end
	end

	cam u_cam (
		.clk            (clk),
		.rst            (rst),
		.write_i        (wr_accept),
		.write_index_i  (wr_ptr),
		.write_data_i   (data_i),
		.search_i       (search_tag_i),
		.search_data_i  (find_tag_i),
		.start_i        (start_index_i),
		.end_i          (end_index_i),
		.search_valid_o (tag_match_o),
		.search_index_o (index_value_o),
		.search_done_o  (search_done_o)
	);

endmodule

// ==== hw/cam.sv ====
`timescale 1ns/1ps

`include "cam_macros.svh"

module cam (
	input  logic               clk,
	input  logic               rst,

	input  logic               write_i,
	input  cam_pkg::cam_addr_t write_index_i,
	input  cam_pkg::cam_data_t write_data_i,

	input  logic               search_i,
	input  cam_pkg::cam_data_t search_data_i,
	input  cam_pkg::cam_addr_t start_i,
	input  cam_pkg::cam_addr_t end_i,

	output logic               search_valid_o,
	output cam_pkg::cam_addr_t search_index_o,
	output logic               search_done_o
);

	import cam_pkg::*;

	localparam int NUM_ENTRIES = (1 << `CAM_ADDR_WIDTH);

	cam_data_t              entry_data [NUM_ENTRIES];
	logic [NUM_ENTRIES-1:0] entry_valid;
	logic [NUM_ENTRIES-1:0] match_vec;
	logic                   enc_hit;
	cam_addr_t              enc_index;

	// a word counts only once its valid bit is set.
	always_ff @(posedge clk) begin
		if (write_i) begin
			entry_data[write_index_i] <= write_data_i;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			entry_valid <= '0;
		end else if (write_i) begin
			entry_valid[write_index_i] <= 1'b1;
		end
	end

	// every entry is compared in parallel against the tag.
	// a write at the same edge only lands after the compare has been sampled.
	always_comb begin
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			match_vec[i] = entry_valid[i] && (entry_data[i] == search_data_i);
		end
	end

	cam_range_encoder #(
		.NUM_ENTRIES (NUM_ENTRIES)
	) u_range_encoder (
		.match_i (match_vec),
		.start_i (start_i),
		.end_i   (end_i),
		.hit_o   (enc_hit),
		.index_o (enc_index)
	);

	// the result is held until the next search and the done flag is a one-cycle pulse.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			search_valid_o <= 1'b0;
			search_index_o <= '0;
		end else if (search_i) begin
			search_valid_o <= enc_hit;
			search_index_o <= enc_index;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			search_done_o <= 1'b0;
		end else begin
			search_done_o <= search_i;
		end
	end

endmodule

// ==== hw/cam_range_encoder.sv ====
`timescale 1ns/1ps

`include "cam_macros.svh"

module cam_range_encoder #(
	parameter int NUM_ENTRIES = (1 << `CAM_ADDR_WIDTH)
) (
	input  logic [NUM_ENTRIES-1:0] match_i,
	input  cam_pkg::cam_addr_t     start_i,
	input  cam_pkg::cam_addr_t     end_i,
	output logic                   hit_o,
	output cam_pkg::cam_addr_t     index_o
);

	import cam_pkg::*;

	logic [NUM_ENTRIES-1:0] window_mask;
	logic [NUM_ENTRIES-1:0] masked_match;

	// an entry is inside the window when start <= i <= end.
	// an inverted window leaves every bit clear, which gives no hit.
	always_comb begin
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			window_mask[i] = (cam_addr_t'(i) >= start_i) && (cam_addr_t'(i) <= end_i);
		end
	end

	assign masked_match = match_i & window_mask;

	// scan from the top down so the last bit taken is the lowest one set.
	always_comb begin
		hit_o   = 1'b0;
		index_o = '0;
		for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
			if (masked_match[i]) begin
				hit_o   = 1'b1;
				index_o = cam_addr_t'(i);
			end
		end
	end

endmodule

// ==== hw/cam_pkg.sv ====
`include "cam_macros.svh"

package cam_pkg;

	// one stored word, or the tag a search looks for.
	typedef logic [`CAM_DATA_WIDTH-1:0] cam_data_t;

	// index of one CAM entry.
	typedef logic [`CAM_ADDR_WIDTH-1:0] cam_addr_t;

	// a finished message is described by the write pointer at its start
	// and at its end strobe.
	typedef struct packed {
		cam_addr_t start_addr;
		cam_addr_t end_addr;
	} msg_desc_t;

endpackage

// ==== include/cam_macros.svh ====
`ifndef CAM_MACROS_SVH
`define CAM_MACROS_SVH

// width of a stored word and of a search tag.
`define CAM_DATA_WIDTH 32

// width of an entry index.
// the CAM holds one entry for every index value, so 5 bits give 32 entries.
`define CAM_ADDR_WIDTH 5

// number of message descriptors the queue can hold.
// the queue needs this to be a power of two.
`define MSG_FIFO_DEPTH 4

`endif
